/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= adapter_tb
FILELIST  ?= membus2csrbus_adapter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, then look for the pass message in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/adapter_pkg.sv */
/*
  Bridge bookkeeping definitions.
  Unit geometry and the records passed from the request splitter
  to the response merger.
*/
package adapter_pkg;

  // CSR units carried by one memory beat.
  localparam int UNITS_PER_BEAT  = bus_pkg::MEM_DATA_WIDTH / bus_pkg::CSR_DATA_WIDTH;
  localparam int UNIT_BYTES      = bus_pkg::CSR_DATA_WIDTH / 8;
  localparam int UNIT_OFFSET_LSB = $clog2(UNIT_BYTES);

  // Non-posted bursts in flight.
  localparam int RESP_QUEUE_DEPTH = 2;

  // Units in one burst, 0 up to MAX_BEATS * UNITS_PER_BEAT.
  typedef logic [$clog2(bus_pkg::MAX_BEATS * UNITS_PER_BEAT + 1)-1:0] unit_count_t;

  typedef struct packed {
    bus_pkg::sresp_e                sresp;
    logic [bus_pkg::ID_WIDTH-1:0]   id;
    logic                           unit_idx;    // Start unit within the first beat.
    logic                           ignore_resp; // Forced non-posted, nothing goes back.
  } resp_info_t;

endpackage

/* logic/bus_pkg.sv */
/*
  Memory and CSR bus definitions.
  Widths, command codes and response kinds shared by both sides.
*/
package bus_pkg;

  // Memory side.
  localparam int MEM_ADDR_WIDTH   = 16;
  localparam int MEM_DATA_WIDTH   = 64;
  localparam int MEM_BYTEEN_WIDTH = MEM_DATA_WIDTH / 8;

  // CSR side.
  localparam int CSR_ADDR_WIDTH = 16;
  localparam int CSR_DATA_WIDTH = 32;

  localparam int ID_WIDTH = 4;

  // Burst length in beats, legal range 1 to MAX_BEATS.
  localparam int MAX_BEATS    = 4;
  localparam int LENGTH_WIDTH = $clog2(MAX_BEATS + 1);

  typedef enum logic [1:0] {
    MCMD_READ             = 2'd0,
    MCMD_WRITE            = 2'd1, // Posted.
    MCMD_WRITE_NON_POSTED = 2'd2
  } mcmd_e;

  typedef enum logic {
    SRESP_RESPONSE           = 1'b0,
    SRESP_RESPONSE_WITH_DATA = 1'b1
  } sresp_e;

endpackage

/* logic/membus2csrbus_adapter.sv */
/*
  Memory bus to CSR bus bridge.
  Splits 64-bit bursts into 32-bit CSR accesses and merges the
  CSR responses back into memory response beats.
*/
module membus2csrbus_adapter (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_force_np_write,
  input  logic                                  i_mem_mcmd_valid,
  input  bus_pkg::mcmd_e                        i_mem_mcmd,
  input  logic [bus_pkg::ID_WIDTH-1:0]          i_mem_mid,
  input  logic [bus_pkg::MEM_ADDR_WIDTH-1:0]    i_mem_maddr,
  input  logic [bus_pkg::LENGTH_WIDTH-1:0]      i_mem_mlength,
  output logic                                  o_mem_scmd_accept,
  input  logic                                  i_mem_mdata_valid,
  input  logic [bus_pkg::MEM_DATA_WIDTH-1:0]    i_mem_mdata,
  input  logic [bus_pkg::MEM_BYTEEN_WIDTH-1:0]  i_mem_mdata_byteen,
  output logic                                  o_mem_sdata_accept,
  output logic                                  o_mem_sresp_valid,
  output bus_pkg::sresp_e                       o_mem_sresp,
  output logic [bus_pkg::ID_WIDTH-1:0]          o_mem_sid,
  output logic [bus_pkg::MEM_DATA_WIDTH-1:0]    o_mem_sdata,
  output logic                                  o_mem_serror,
  output logic                                  o_mem_sresp_last,
  input  logic                                  i_mem_mresp_accept,
  output logic                                  o_csr_mcmd_valid,
  output bus_pkg::mcmd_e                        o_csr_mcmd,
  output logic [bus_pkg::CSR_ADDR_WIDTH-1:0]    o_csr_maddr,
  output logic [bus_pkg::CSR_DATA_WIDTH-1:0]    o_csr_mdata,
  input  logic                                  i_csr_scmd_accept,
  input  logic                                  i_csr_sresp_valid,
  input  logic [bus_pkg::CSR_DATA_WIDTH-1:0]    i_csr_sdata,
  input  logic                                  i_csr_serror,
  output logic                                  o_csr_mresp_accept
);
  import adapter_pkg::*;

  logic         info_push;
  logic         info_full;
  logic         info_empty;
  resp_info_t   info_in;
  resp_info_t   info_head;
  logic         count_push;
  logic         count_empty;
  unit_count_t  count_in;
  unit_count_t  count_head;
  logic         pop;

  request_splitter u_splitter (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_force_np_write   (i_force_np_write),
    .i_mem_mcmd_valid   (i_mem_mcmd_valid),
    .i_mem_mcmd         (i_mem_mcmd),
    .i_mem_mid          (i_mem_mid),
    .i_mem_maddr        (i_mem_maddr),
    .i_mem_mlength      (i_mem_mlength),
    .i_mem_mdata_valid  (i_mem_mdata_valid),
    .i_mem_mdata        (i_mem_mdata),
    .i_mem_mdata_byteen (i_mem_mdata_byteen),
    .i_csr_scmd_accept  (i_csr_scmd_accept),
    .i_info_full        (info_full),
    .o_mem_scmd_accept  (o_mem_scmd_accept),
    .o_mem_sdata_accept (o_mem_sdata_accept),
    .o_csr_mcmd_valid   (o_csr_mcmd_valid),
    .o_csr_mcmd         (o_csr_mcmd),
    .o_csr_maddr        (o_csr_maddr),
    .o_csr_mdata        (o_csr_mdata),
    .o_info_push        (info_push),
    .o_info             (info_in),
    .o_count_push       (count_push),
    .o_count            (count_in)
  );

  // Both queues pop together, one entry per non-posted burst.
  response_queue #(
    .ENTRY_T (resp_info_t),
    .DEPTH   (RESP_QUEUE_DEPTH)
  ) u_info_queue (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (info_push),
    .i_data  (info_in),
    .i_pop   (pop),
    .o_empty (info_empty),
    .o_full  (info_full),
    .o_data  (info_head)
  );

  response_queue #(
    .ENTRY_T (unit_count_t),
    .DEPTH   (RESP_QUEUE_DEPTH)
  ) u_count_queue (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (count_push),
    .i_data  (count_in),
    .i_pop   (pop),
    .o_empty (count_empty),
    .o_full  (),
    .o_data  (count_head)
  );

  response_merger u_merger (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_info_empty       (info_empty),
    .i_info             (info_head),
    .i_count_empty      (count_empty),
    .i_count            (count_head),
    .i_csr_sresp_valid  (i_csr_sresp_valid),
    .i_csr_sdata        (i_csr_sdata),
    .i_csr_serror       (i_csr_serror),
    .i_mem_mresp_accept (i_mem_mresp_accept),
    .o_pop              (pop),
    .o_csr_mresp_accept (o_csr_mresp_accept),
    .o_mem_sresp_valid  (o_mem_sresp_valid),
    .o_mem_sresp        (o_mem_sresp),
    .o_mem_sid          (o_mem_sid),
    .o_mem_sdata        (o_mem_sdata),
    .o_mem_serror       (o_mem_serror),
    .o_mem_sresp_last   (o_mem_sresp_last)
  );

endmodule

/* logic/request_splitter.sv */
/*
  Request splitter.
  Cuts each memory burst into single CSR unit accesses, skips write
  units without byte enables and records what comes back.
*/
module request_splitter (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_force_np_write,
  input  logic                                  i_mem_mcmd_valid,
  input  bus_pkg::mcmd_e                        i_mem_mcmd,
  input  logic [bus_pkg::ID_WIDTH-1:0]          i_mem_mid,
  input  logic [bus_pkg::MEM_ADDR_WIDTH-1:0]    i_mem_maddr,
  input  logic [bus_pkg::LENGTH_WIDTH-1:0]      i_mem_mlength,
  input  logic                                  i_mem_mdata_valid,
  input  logic [bus_pkg::MEM_DATA_WIDTH-1:0]    i_mem_mdata,
  input  logic [bus_pkg::MEM_BYTEEN_WIDTH-1:0]  i_mem_mdata_byteen,
  input  logic                                  i_csr_scmd_accept,
  input  logic                                  i_info_full,
  output logic                                  o_mem_scmd_accept,
  output logic                                  o_mem_sdata_accept,
  output logic                                  o_csr_mcmd_valid,
  output bus_pkg::mcmd_e                        o_csr_mcmd,
  output logic [bus_pkg::CSR_ADDR_WIDTH-1:0]    o_csr_maddr,
  output logic [bus_pkg::CSR_DATA_WIDTH-1:0]    o_csr_mdata,
  output logic                                  o_info_push,
  output adapter_pkg::resp_info_t               o_info,
  output logic                                  o_count_push,
  output adapter_pkg::unit_count_t              o_count
);
  import bus_pkg::*;
  import adapter_pkg::*;

  logic                       busy;
  unit_count_t                rem_q;
  logic                       idx_q;
  logic [CSR_ADDR_WIDTH-1:0]  addr_q;
  unit_count_t                issued_q;

  unit_count_t                cur_rem;
  logic                       cur_idx;
  logic [CSR_ADDR_WIDTH-1:0]  cur_addr;
  unit_count_t                cur_issued;
  unit_count_t                issued_next;
  mcmd_e                      mcmd_eff;
  logic                       is_read;
  logic                       expects_resp;
  logic                       np_ready;
  logic                       last_unit;
  logic                       skip;
  logic                       valid_rd;
  logic                       valid_wr;
  logic                       issued;
  logic                       unit_done;

  always_comb begin
    if (i_force_np_write && (i_mem_mcmd == MCMD_WRITE)) begin
      mcmd_eff = MCMD_WRITE_NON_POSTED;
    end else begin
      mcmd_eff = i_mem_mcmd;
    end
    is_read      = i_mem_mcmd == MCMD_READ;
    expects_resp = mcmd_eff != MCMD_WRITE;
  end

  // First unit comes from the command, later ones from the registers.
  always_comb begin
    if (busy) begin
      cur_rem    = rem_q;
      cur_idx    = idx_q;
      cur_addr   = addr_q;
      cur_issued = issued_q;
    end else begin
      cur_rem    = unit_count_t'(i_mem_mlength) * unit_count_t'(UNITS_PER_BEAT)
                   - unit_count_t'(i_mem_maddr[UNIT_OFFSET_LSB]);
      cur_idx    = i_mem_maddr[UNIT_OFFSET_LSB];
      cur_addr   = {i_mem_maddr[CSR_ADDR_WIDTH-1:UNIT_OFFSET_LSB], UNIT_OFFSET_LSB'(0)};
      cur_issued = '0;
    end
  end

  always_comb begin
    np_ready  = busy || !i_info_full || !expects_resp; // Room for the record.
    last_unit = cur_rem == unit_count_t'(1);
    skip      = !is_read && (i_mem_mdata_byteen[cur_idx*UNIT_BYTES +: UNIT_BYTES] == '0);
    valid_rd  = i_mem_mcmd_valid && is_read && np_ready;
    valid_wr  = i_mem_mcmd_valid && !is_read && i_mem_mdata_valid && np_ready;

    o_csr_mcmd_valid = valid_rd || (valid_wr && !skip);
    o_csr_mcmd       = mcmd_eff;
    o_csr_maddr      = cur_addr;
    o_csr_mdata      = i_mem_mdata[cur_idx*CSR_DATA_WIDTH +: CSR_DATA_WIDTH];

    issued      = o_csr_mcmd_valid && i_csr_scmd_accept;
    unit_done   = issued || (valid_wr && skip);
    issued_next = cur_issued + unit_count_t'(issued);

    o_mem_scmd_accept  = unit_done && last_unit;
    o_mem_sdata_accept = unit_done && !is_read && (cur_idx || last_unit);
  end

  // Records for the response side.
  always_comb begin
    o_info_push        = unit_done && !busy && expects_resp;
    o_info.sresp       = is_read ? SRESP_RESPONSE_WITH_DATA : SRESP_RESPONSE;
    o_info.id          = i_mem_mid;
    o_info.unit_idx    = i_mem_maddr[UNIT_OFFSET_LSB];
    o_info.ignore_resp = i_force_np_write && (i_mem_mcmd == MCMD_WRITE);
    o_count_push       = unit_done && last_unit && expects_resp;
    o_count            = issued_next;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      rem_q    <= '0;
      idx_q    <= 1'b0;
      addr_q   <= '0;
      issued_q <= '0;
    end else if (unit_done) begin
      busy     <= !last_unit;
      rem_q    <= cur_rem - unit_count_t'(1);
      idx_q    <= ~cur_idx;
      addr_q   <= cur_addr + CSR_ADDR_WIDTH'(UNIT_BYTES);
      issued_q <= issued_next;
    end
  end

endmodule

/* logic/response_merger.sv */
/*
  Response merger.
  Gathers CSR unit responses of the head burst into 64-bit memory
  response beats, or one write response at the end.
*/
module response_merger (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_info_empty,
  input  adapter_pkg::resp_info_t             i_info,
  input  logic                                i_count_empty,
  input  adapter_pkg::unit_count_t            i_count,
  input  logic                                i_csr_sresp_valid,
  input  logic [bus_pkg::CSR_DATA_WIDTH-1:0]  i_csr_sdata,
  input  logic                                i_csr_serror,
  input  logic                                i_mem_mresp_accept,
  output logic                                o_pop,
  output logic                                o_csr_mresp_accept,
  output logic                                o_mem_sresp_valid,
  output bus_pkg::sresp_e                     o_mem_sresp,
  output logic [bus_pkg::ID_WIDTH-1:0]        o_mem_sid,
  output logic [bus_pkg::MEM_DATA_WIDTH-1:0]  o_mem_sdata,
  output logic                                o_mem_serror,
  output logic                                o_mem_sresp_last
);
  import bus_pkg::*;
  import adapter_pkg::*;

  logic                       busy;
  unit_count_t                recv_q;
  logic                       slot_q;
  logic [CSR_DATA_WIDTH-1:0]  lo_data_q;
  logic                       err_q;

  unit_count_t                cur_recv;
  unit_count_t                recv_next;
  logic                       cur_slot;
  logic                       head_valid;
  logic                       is_read;
  logic                       final_unit;
  logic                       zero_cnt;
  logic                       emit;
  logic                       resp_ack;
  logic                       err;

  always_comb begin
    head_valid = !i_info_empty;
    cur_recv   = busy ? recv_q : '0;
    cur_slot   = busy ? slot_q : i_info.unit_idx; // Starts at the recorded unit.
    recv_next  = cur_recv + unit_count_t'(1);
    is_read    = i_info.sresp == SRESP_RESPONSE_WITH_DATA;
    final_unit = !i_count_empty && (recv_next == i_count);
    zero_cnt   = head_valid && !i_count_empty && (i_count == '0); // All units skipped.
  end

  // Read beat on the upper slot or at the end, write only at the end.
  always_comb begin
    if (!head_valid || i_info.ignore_resp) begin
      emit = 1'b0;
    end else if (is_read) begin
      emit = cur_slot || final_unit;
    end else begin
      emit = final_unit;
    end
    if (!head_valid || zero_cnt) begin
      o_csr_mresp_accept = 1'b0;
    end else if (emit) begin
      o_csr_mresp_accept = i_mem_mresp_accept; // Held under back-pressure.
    end else begin
      o_csr_mresp_accept = 1'b1;
    end
    resp_ack = i_csr_sresp_valid && o_csr_mresp_accept;
    o_pop    = (resp_ack && final_unit) || zero_cnt;
    err      = err_q || i_csr_serror;
  end

  always_comb begin
    o_mem_sresp_valid = emit && i_csr_sresp_valid;
    o_mem_sresp       = i_info.sresp;
    o_mem_sid         = i_info.id;
    o_mem_serror      = err;
    o_mem_sresp_last  = final_unit;
    if (!is_read) begin
      o_mem_sdata = '0;
    end else if (cur_slot) begin
      o_mem_sdata = {i_csr_sdata, lo_data_q};
    end else begin
      o_mem_sdata = {CSR_DATA_WIDTH'(0), i_csr_sdata};
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy   <= 1'b0;
      recv_q <= '0;
      slot_q <= 1'b0;
    end else if (resp_ack) begin
      busy   <= !final_unit;
      recv_q <= recv_next;
      slot_q <= ~cur_slot;
    end
  end

  // Lower half and sticky error live until their beat goes out.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lo_data_q <= '0;
      err_q     <= 1'b0;
    end else if (resp_ack) begin
      if (emit || final_unit) begin
        lo_data_q <= '0;
        err_q     <= 1'b0;
      end else begin
        if (!cur_slot) begin
          lo_data_q <= i_csr_sdata;
        end
        err_q <= err;
      end
    end
  end

endmodule

/* logic/response_queue.sv */
/*
  Response queue.
  Small circular FIFO for any entry type; a push shows at the head
  one cycle later.
*/
module response_queue #(
  parameter type ENTRY_T = logic,
  parameter int  DEPTH   = 2
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_push,
  input  ENTRY_T i_data,
  input  logic   i_pop,
  output logic   o_empty,
  output logic   o_full,
  output ENTRY_T o_data
);
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  ENTRY_T                 mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [CNT_WIDTH-1:0]   count;
  logic                   do_push;
  logic                   do_pop;

  always_comb begin
    o_empty = count == '0;
    o_full  = count == CNT_WIDTH'(DEPTH);
    o_data  = mem[rd_ptr];
    do_push = i_push && !o_full;
    do_pop  = i_pop && !o_empty;
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_WIDTH'(do_push) - CNT_WIDTH'(do_pop);
    end
  end

endmodule

/* membus2csrbus_adapter.f */
logic/bus_pkg.sv
logic/adapter_pkg.sv
logic/request_splitter.sv
logic/response_queue.sv
logic/response_merger.sv
logic/membus2csrbus_adapter.sv
verification/adapter_tb.sv

/* verification/adapter_tb.sv */
/*
  Directed testbench for the memory bus to CSR bus bridge.
  A CSR target model answers with random stalls and delays.
*/
module adapter_tb;
  import bus_pkg::*;

  localparam int NUM_TESTS = 6;

  typedef struct {
    sresp_e                    sresp;
    logic [ID_WIDTH-1:0]       id;
    logic [MEM_DATA_WIDTH-1:0] data;
    logic                      err;
    logic                      last;
    int                        units; // CSR responses taken so far.
  } mem_beat_t;

  logic i_clk, i_rst_n, i_force_np_write;
  logic i_mem_mcmd_valid, o_mem_scmd_accept, i_mem_mdata_valid, o_mem_sdata_accept;
  mcmd_e i_mem_mcmd, o_csr_mcmd;
  logic [ID_WIDTH-1:0] i_mem_mid, o_mem_sid;
  logic [MEM_ADDR_WIDTH-1:0] i_mem_maddr;
  logic [LENGTH_WIDTH-1:0] i_mem_mlength;
  logic [MEM_DATA_WIDTH-1:0] i_mem_mdata, o_mem_sdata;
  logic [MEM_BYTEEN_WIDTH-1:0] i_mem_mdata_byteen;
  logic o_mem_sresp_valid, o_mem_serror, o_mem_sresp_last, i_mem_mresp_accept;
  sresp_e o_mem_sresp;
  logic o_csr_mcmd_valid, i_csr_scmd_accept, o_csr_mresp_accept;
  logic i_csr_sresp_valid, i_csr_serror;
  logic [CSR_ADDR_WIDTH-1:0] o_csr_maddr;
  logic [CSR_DATA_WIDTH-1:0] o_csr_mdata, i_csr_sdata;

  integer                    seed = 32'h5bea_4098;
  int                        errors = 0;
  int                        csr_resp_cnt = 0;
  logic [CSR_DATA_WIDTH-1:0] regs [16] = '{default: '0}; // Target registers.
  logic [CSR_DATA_WIDTH:0]   csr_pend [$];                // Pending {serror, sdata} in order.
  mcmd_e                     cmd_log [$];
  logic [CSR_ADDR_WIDTH-1:0] addr_log [$];
  mem_beat_t                 got [$];
  logic [MEM_DATA_WIDTH-1:0] wr_data [MAX_BEATS] = '{default: '0};

  membus2csrbus_adapter dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    #(NUM_TESTS * 2000);
    $display("Watchdog expired before the tests finished.");
    $display("*** FAILED ***");
    $finish;
  end

  // CSR target and memory response monitor. Samples on the rising edge and drives on the falling one.
  initial begin
    logic      taken;
    mem_beat_t beat;
    i_csr_scmd_accept  = 1'b0;
    i_csr_sresp_valid  = 1'b0;
    i_csr_sdata        = '0;
    i_csr_serror       = 1'b0;
    i_mem_mresp_accept = 1'b0;
    forever begin
      @(posedge i_clk);
      taken = i_csr_sresp_valid && o_csr_mresp_accept;
      if (taken) begin
        void'(csr_pend.pop_front());
        csr_resp_cnt++;
      end
      if (o_csr_mcmd_valid && i_csr_scmd_accept) begin
        cmd_log.push_back(o_csr_mcmd);
        addr_log.push_back(o_csr_maddr);
        if (o_csr_mcmd == MCMD_READ) begin
          csr_pend.push_back({o_csr_maddr >= 16'h0040, regs[o_csr_maddr[5:2]]});
        end else begin
          regs[o_csr_maddr[5:2]] = o_csr_mdata;
          if (o_csr_mcmd == MCMD_WRITE_NON_POSTED) begin
            csr_pend.push_back({o_csr_maddr >= 16'h0040, 32'h0}); // Posted gets none.
          end
        end
      end
      if (o_mem_sresp_valid && i_mem_mresp_accept) begin
        beat.sresp = o_mem_sresp;
        beat.id    = o_mem_sid;
        beat.data  = o_mem_sdata;
        beat.err   = o_mem_serror;
        beat.last  = o_mem_sresp_last;
        beat.units = csr_resp_cnt;
        got.push_back(beat);
      end
      @(negedge i_clk);
      i_csr_scmd_accept  = ($random(seed) & 3) != 0;
      i_mem_mresp_accept = ($random(seed) & 3) != 0;
      if (taken) i_csr_sresp_valid = 1'b0;
      if (!i_csr_sresp_valid && csr_pend.size() > 0 && ($random(seed) & 1) != 0) begin
        i_csr_sresp_valid           = 1'b1;
        {i_csr_serror, i_csr_sdata} = csr_pend[0];
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got_v,
                                 input logic [63:0] exp_v);
    errors++;
    $display("CHECK FAILED %s: got %0h, expected %0h", name, got_v, exp_v);
  endtask

  task automatic check_sresp(input string name, input sresp_e got_v, input sresp_e exp_v);
    if (got_v !== exp_v) report_mismatch(name, 64'(got_v), 64'(exp_v));
  endtask

  task automatic check_id(input string name, input logic [ID_WIDTH-1:0] got_v,
                          input logic [ID_WIDTH-1:0] exp_v);
    if (got_v !== exp_v) report_mismatch(name, 64'(got_v), 64'(exp_v));
  endtask

  task automatic check_data(input string name, input logic [MEM_DATA_WIDTH-1:0] got_v,
                            input logic [MEM_DATA_WIDTH-1:0] exp_v);
    if (got_v !== exp_v) report_mismatch(name, got_v, exp_v);
  endtask

  task automatic check_addr(input string name, input logic [CSR_ADDR_WIDTH-1:0] got_v,
                            input logic [CSR_ADDR_WIDTH-1:0] exp_v);
    if (got_v !== exp_v) report_mismatch(name, 64'(got_v), 64'(exp_v));
  endtask

  task automatic check_flag(input string name, input logic got_v, input logic exp_v);
    if (got_v !== exp_v) report_mismatch(name, 64'(got_v), 64'(exp_v));
  endtask

  task automatic check_mcmd(input string name, input mcmd_e got_v, input mcmd_e exp_v);
    if (got_v !== exp_v) report_mismatch(name, 64'(got_v), 64'(exp_v));
  endtask

  task automatic expect_count(input string what, input int got_n, input int exp_n);
    if (got_n != exp_n) begin
      errors++;
      $display("Wrong number of %s: %0d instead of %0d.", what, got_n, exp_n);
    end
  endtask

  task automatic clear_records();
    got.delete();
    cmd_log.delete();
    addr_log.delete();
  endtask

  // Holds the command until its last unit and each data beat until it is taken.
  task automatic send_burst(input mcmd_e cmd, input logic [ID_WIDTH-1:0] id,
                            input logic [MEM_ADDR_WIDTH-1:0] addr, input int len,
                            input logic [MEM_BYTEEN_WIDTH-1:0] be);
    int   beat;
    logic cmd_acc;
    logic data_acc;
    beat               = 0;
    i_mem_mcmd_valid   = 1'b1;
    i_mem_mcmd         = cmd;
    i_mem_mid          = id;
    i_mem_maddr        = addr;
    i_mem_mlength      = LENGTH_WIDTH'(len);
    i_mem_mdata_valid  = cmd != MCMD_READ;
    i_mem_mdata        = wr_data[0];
    i_mem_mdata_byteen = be;
    while (i_mem_mcmd_valid) begin
      @(posedge i_clk);
      cmd_acc  = o_mem_scmd_accept;
      data_acc = o_mem_sdata_accept;
      @(negedge i_clk);
      if (data_acc) begin
        beat++;
        i_mem_mdata_valid = beat < len;
        i_mem_mdata       = wr_data[beat % MAX_BEATS];
      end
      if (cmd_acc) i_mem_mcmd_valid = 1'b0;
    end
  endtask

  task automatic wait_responses(input int n);
    while (got.size() < n) @(negedge i_clk);
  endtask

  task automatic wait_target_idle();
    while (csr_pend.size() > 0) @(negedge i_clk);
    repeat (4) @(negedge i_clk); // Room for a stray response.
  endtask

  task automatic aligned_write_read();
    clear_records();
    wr_data[0] = {$random(seed), $random(seed)};
    wr_data[1] = {$random(seed), $random(seed)};
    send_burst(MCMD_WRITE, 4'h1, 16'h0000, 2, 8'hFF);
    wait_target_idle();
    expect_count("responses to the posted write", got.size(), 0);
    send_burst(MCMD_READ, 4'h3, 16'h0000, 2, 8'h00);
    wait_responses(2);
    for (int b = 0; b < 2; b++) begin
      check_sresp("o_mem_sresp", got[b].sresp, SRESP_RESPONSE_WITH_DATA);
      check_id("o_mem_sid", got[b].id, 4'h3);
      check_data("o_mem_sdata", got[b].data, wr_data[b]);
      check_flag("o_mem_sresp_last", got[b].last, b == 1);
    end
  endtask

  task automatic unaligned_read();
    clear_records();
    send_burst(MCMD_READ, 4'h5, 16'h0004, 2, 8'h00);
    wait_responses(2);
    expect_count("CSR accesses", cmd_log.size(), 3);
    check_data("o_mem_sdata[63:32]", 64'(got[0].data[63:32]), 64'(wr_data[0][63:32]));
    check_data("o_mem_sdata", got[1].data, wr_data[1]);
  endtask

  task automatic byteen_skip();
    logic [CSR_DATA_WIDTH-1:0] old_lo;
    old_lo = wr_data[0][31:0];
    clear_records();
    wr_data[0] = {$random(seed), $random(seed)};
    send_burst(MCMD_WRITE, 4'h7, 16'h0000, 1, 8'hF0);
    expect_count("CSR writes", cmd_log.size(), 1);
    check_addr("o_csr_maddr", addr_log[0], 16'h0004);
    send_burst(MCMD_READ, 4'h7, 16'h0000, 1, 8'h00);
    wait_responses(1);
    check_data("o_mem_sdata", got[0].data, {wr_data[0][63:32], old_lo});
  endtask

  task automatic non_posted_write();
    int base;
    clear_records();
    base = csr_resp_cnt;
    send_burst(MCMD_WRITE_NON_POSTED, 4'h9, 16'h0010, 2, 8'hFF);
    wait_responses(1);
    wait_target_idle();
    expect_count("responses to the non-posted write", got.size(), 1);
    check_sresp("o_mem_sresp", got[0].sresp, SRESP_RESPONSE);
    check_id("o_mem_sid", got[0].id, 4'h9);
    check_flag("o_mem_sresp_last", got[0].last, 1'b1);
    expect_count("CSR responses ahead of the memory response", got[0].units - base, 4);
  endtask

  task automatic forced_non_posted();
    clear_records();
    i_force_np_write = 1'b1;
    send_burst(MCMD_WRITE, 4'hA, 16'h0020, 2, 8'hFF);
    wait_target_idle();
    i_force_np_write = 1'b0;
    expect_count("CSR writes", cmd_log.size(), 4);
    foreach (cmd_log[i]) begin
      check_mcmd("o_csr_mcmd", cmd_log[i], MCMD_WRITE_NON_POSTED);
    end
    expect_count("responses to the forced write", got.size(), 0);
  endtask

  task automatic error_read();
    clear_records();
    send_burst(MCMD_READ, 4'h2, 16'h0038, 2, 8'h00); // Second beat at 16'h0040.
    wait_responses(2);
    check_flag("o_mem_serror", got[0].err, 1'b0);
    check_flag("o_mem_serror", got[1].err, 1'b1);
    check_id("o_mem_sid", got[1].id, 4'h2);
  endtask

  initial begin
    i_rst_n            = 1'b0;
    i_force_np_write   = 1'b0;
    i_mem_mcmd_valid   = 1'b0;
    i_mem_mcmd         = MCMD_READ;
    i_mem_mid          = '0;
    i_mem_maddr        = '0;
    i_mem_mlength      = '0;
    i_mem_mdata_valid  = 1'b0;
    i_mem_mdata        = '0;
    i_mem_mdata_byteen = '0;
    repeat (3) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_flag("o_mem_scmd_accept", o_mem_scmd_accept, 1'b0);
    check_flag("o_mem_sdata_accept", o_mem_sdata_accept, 1'b0);
    check_flag("o_csr_mcmd_valid", o_csr_mcmd_valid, 1'b0);
    check_flag("o_mem_sresp_valid", o_mem_sresp_valid, 1'b0);
    check_flag("o_csr_mresp_accept", o_csr_mresp_accept, 1'b0);
    aligned_write_read();
    unaligned_read();
    byteen_skip();
    non_posted_write();
    forced_non_posted();
    error_read();
    $display("Run complete: %0d tests, %0d errors.", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
